/* filelist.f */
+incdir+.
gcm_pkg.sv
gf128_multiplier.sv
block_timer.sv
tag_sequencer_fsm.sv
ghash_accumulator.sv
tag_checker.sv
gcm_tag_verify.sv
tb_clock_gen.sv
tb_checker.sv
tb_gcm_tag_verify.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_gcm_tag_verify
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_gcm_tag_verify.sv */
// ==============================
// Random GCM frames against a GHASH model with a fixed seed.
// Inputs change on the falling edge only.
// ==============================
`timescale 1ns/1ns
`include "ghash_settings.svh"

module tb_gcm_tag_verify;

    localparam int              RESET_LIMIT   = 64;
    localparam int              READY_LIMIT   = 600;
    localparam int              VERDICT_LIMIT = 1000;
    localparam int              FRAME_COUNT   = 6;
    localparam gcm_pkg::block_t R_POLY        = {8'he1, 120'd0};
    localparam gcm_pkg::block_t ALL_ONES      = '1;

    logic                clock;
    logic                reset;
    logic                valid;
    logic                sop;
    gcm_pkg::frame_hdr_t hdr;
    gcm_pkg::block_t     text;
    logic                clear_fault;
    logic                ready;
    logic                tag_valid;
    logic                fail;
    logic                fault_sop_busy;

    logic [31:0] lcg_state = 32'h4eb7;
    logic        timed_out = 1'b0;

    tb_clock_gen i_tb_clock_gen
    (
        .o_clock (clock),
        .o_reset (reset)
    );

    gcm_tag_verify i_gcm_tag_verify
    (
        .i_clock          (clock),
        .i_reset          (reset),
        .i_valid          (valid),
        .i_sop            (sop),
        .i_hdr            (hdr),
        .i_text           (text),
        .i_clear_fault    (clear_fault),
        .o_ready          (ready),
        .o_tag_valid      (tag_valid),
        .o_fail           (fail),
        .o_fault_sop_busy (fault_sop_busy)
    );

    tb_checker i_tb_checker
    (
        .i_clock          (clock),
        .i_reset          (reset),
        .i_ready          (ready),
        .i_tag_valid      (tag_valid),
        .i_fail           (fail),
        .i_fault_sop_busy (fault_sop_busy)
    );

    // ==============================
    // Random numbers and the GHASH model.
    // ==============================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic gcm_pkg::block_t random_block();
        gcm_pkg::block_t blk;
        blk = '0;
        for (int i = 0; i < 4; i++)
        begin
            blk = {blk[95:0], lcg_next()};
        end
        return blk;
    endfunction

    // X times H as in SP 800-38D, X bit 0 is the MSB here.
    function automatic gcm_pkg::block_t gf_multiply(input gcm_pkg::block_t x,
                                                    input gcm_pkg::block_t h);
        gcm_pkg::block_t z;
        gcm_pkg::block_t v;
        z = '0;
        v = h;
        for (int i = 0; i < `GCM_NB_BLOCK; i++)
        begin
            if (x[`GCM_NB_BLOCK - 1 - i])
            begin
                z = z ^ v;
            end
            if (v[0])
            begin
                v = (v >> 1) ^ R_POLY;
            end
            else
            begin
                v = v >> 1;
            end
        end
        return z;
    endfunction

    // ==============================
    // Waits, each bounded.
    // ==============================
    task automatic wait_reset_release();
        int cnt;
        cnt = 0;
        while (reset && cnt < RESET_LIMIT)
        begin
            @(negedge clock);
            cnt++;
        end
        if (reset)
        begin
            timed_out = 1'b1;
            $display("Timeout: reset never released");
        end
    endtask

    task automatic wait_ready(input string name);
        int cnt;
        cnt = 0;
        while (!ready && cnt < READY_LIMIT)
        begin
            @(negedge clock);
            cnt++;
        end
        if (!ready)
        begin
            timed_out = 1'b1;
            $display("Timeout: o_ready stayed low for a text beat of %s", name);
        end
    endtask

    // One more cycle after the pulse moves the DUT from DONE to IDLE.
    task automatic wait_verdict(input string name);
        int cnt;
        cnt = 0;
        while (!tag_valid && cnt < VERDICT_LIMIT)
        begin
            @(negedge clock);
            cnt++;
        end
        if (!tag_valid)
        begin
            timed_out = 1'b1;
            $display("Timeout: no o_tag_valid for %s", name);
        end
        else
        begin
            @(negedge clock);
        end
    endtask

    // ==============================
    // One frame: header, optional busy i_sop, text beats, verdict.
    // ==============================
    task automatic run_frame(input string name, input int nblocks, input logic corrupt,
                             input logic gaps, input logic inject_sop);
        gcm_pkg::frame_hdr_t frame;
        gcm_pkg::block_t     blocks [0:7];
        gcm_pkg::block_t     y;
        int                  aad_bits;
        int                  flip_bit;
        int                  gap;
        if (timed_out)
        begin
            return;
        end
        // AAD is zero-padded past its bit length.
        aad_bits          = 1 + int'(lcg_next() % 32'd128);
        frame.hash_key    = random_block();
        frame.aad         = random_block() & ~(ALL_ONES >> aad_bits);
        frame.length_aad  = 64'(aad_bits);
        frame.length_text = 64'(nblocks) << `GCM_LOG2_BLOCK_BITS;
        frame.tag_mask    = random_block();
        for (int b = 0; b < nblocks; b++)
        begin
            blocks[b] = random_block();
        end
        // Y starts at zero, so the first product is A times H.
        y = gf_multiply(frame.aad, frame.hash_key);
        for (int b = 0; b < nblocks; b++)
        begin
            y = gf_multiply(y ^ blocks[b], frame.hash_key);
        end
        y         = gf_multiply(y ^ {frame.length_aad, frame.length_text}, frame.hash_key);
        frame.tag = y ^ frame.tag_mask;
        // Drawn every time, so the same seed gives the same frames.
        flip_bit = int'(lcg_next() % 32'd128);
        if (corrupt)
        begin
            frame.tag = frame.tag ^ (gcm_pkg::block_t'(1) << flip_bit);
        end
        i_tb_checker.expect_verdict(name, corrupt);

        // Header beat for one cycle, the DUT is in IDLE here.
        hdr   = frame;
        valid = 1'b1;
        sop   = 1'b1;
        @(negedge clock);
        valid = 1'b0;
        sop   = 1'b0;

        // Second header while the AAD block is in the multiplier.
        if (inject_sop)
        begin
            hdr.tag = random_block();
            valid   = 1'b1;
            sop     = 1'b1;
            @(negedge clock);
            valid = 1'b0;
            sop   = 1'b0;
            i_tb_checker.check_fault({name, " fault set"}, 1'b1);
            clear_fault = 1'b1;
            @(negedge clock);
            clear_fault = 1'b0;
            i_tb_checker.check_fault({name, " fault clear"}, 1'b0);
        end

        for (int b = 0; b < nblocks; b++)
        begin
            if (gaps)
            begin
                // Junk on the bus with i_valid low while o_ready is high.
                wait_ready(name);
                if (timed_out)
                begin
                    return;
                end
                gap = 1 + int'(lcg_next() % 32'd3);
                repeat (gap)
                begin
                    text = random_block();
                    @(negedge clock);
                end
            end
            valid = 1'b1;
            text  = blocks[b];
            wait_ready(name);
            if (timed_out)
            begin
                return;
            end
            // Taken on the rising edge in between.
            @(negedge clock);
            valid = 1'b0;
            text  = '0;
        end
        wait_verdict(name);
    endtask

    // ==============================
    // Test sequence.
    // ==============================
    initial
    begin : stimulus
        logic [31:0] saved_state;
        int          failures;
        valid       = 1'b0;
        sop         = 1'b0;
        hdr         = '0;
        text        = '0;
        clear_fault = 1'b0;

        repeat (4) @(negedge clock);
        i_tb_checker.check_quiet("reset_hold");
        wait_reset_release();
        @(negedge clock);
        i_tb_checker.check_quiet("reset_release");

        // Good tags, then the same frames with one tag bit flipped.
        saved_state = lcg_state;
        for (int k = 0; k < FRAME_COUNT; k++)
        begin
            run_frame($sformatf("frame_ok_%0d", k), 1 + int'(lcg_next() % 32'd6), 1'b0, 1'b0,
                      1'b0);
        end
        lcg_state = saved_state;
        for (int k = 0; k < FRAME_COUNT; k++)
        begin
            run_frame($sformatf("frame_bad_%0d", k), 1 + int'(lcg_next() % 32'd6), 1'b1, 1'b0,
                      1'b0);
        end

        run_frame("frame_no_text", 0, 1'b0, 1'b0, 1'b0);

        for (int k = 0; k < 4; k++)
        begin
            run_frame($sformatf("frame_gaps_%0d", k), 1 + int'(lcg_next() % 32'd6), k == 3,
                      1'b1, 1'b0);
        end

        run_frame("frame_sop_busy", 3, 1'b0, 1'b0, 1'b1);
        if (!timed_out)
        begin
            i_tb_checker.check_fault("fault_after_frame", 1'b0);
        end

        i_tb_checker.finish_report(failures);
        if (!timed_out && failures == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb_checker.sv */
// ==============================
// Compares DUT outputs with expected values from the testbench top.
// Verdicts are matched to frames in arrival order.
// ==============================
`timescale 1ns/1ns

module tb_checker
(
    input logic i_clock,
    input logic i_reset,
    input logic i_ready,
    input logic i_tag_valid,
    input logic i_fail,
    input logic i_fault_sop_busy
);

    string names_q [$];
    logic  verdict_q [$];
    int    pass_count = 0;
    int    fail_count = 0;

    // One result line per check.
    task automatic record_check(input string name, input logic [3:0] exp_val,
                                input logic [3:0] act_val);
        if (exp_val === act_val)
        begin
            pass_count++;
            $display("Pass %s", name);
        end
        else
        begin
            fail_count++;
            $display("Fail %s: expected %0b, actual %0b", name, exp_val, act_val);
        end
    endtask

    // Frame started, its o_fail value is known up front.
    task automatic expect_verdict(input string name, input logic exp_fail);
        names_q.push_back(name);
        verdict_q.push_back(exp_fail);
    endtask

    // Order is ready, tag_valid, fail, fault.
    task automatic check_quiet(input string name);
        record_check(name, 4'b0000, {i_ready, i_tag_valid, i_fail, i_fault_sop_busy});
    endtask

    task automatic check_fault(input string name, input logic exp_fault);
        record_check(name, {3'b000, exp_fault}, {3'b000, i_fault_sop_busy});
    endtask

    // ==============================
    // Verdict watch.
    // ==============================

    // Outputs settle after the rising edge, so look on the falling one.
    always @(negedge i_clock)
    begin : verdict_watch
        string name;
        logic  exp_fail;
        if (!i_reset && i_tag_valid)
        begin
            if (names_q.size() == 0)
            begin
                fail_count++;
                $display("Error: o_tag_valid pulsed with no frame in flight");
            end
            else
            begin
                name     = names_q.pop_front();
                exp_fail = verdict_q.pop_front();
                record_check(name, {3'b000, exp_fail}, {3'b000, i_fail});
            end
        end
    end

    // Frames still waiting here never got o_tag_valid.
    task automatic finish_report(output int failures);
        if (names_q.size() != 0)
        begin
            $display("Error: %0d frames ended without o_tag_valid", names_q.size());
            fail_count += names_q.size();
        end
        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        failures = fail_count;
    endtask

endmodule

/* tb_clock_gen.sv */
// ==============================
// Testbench clock, 10 ns period.
// Reset is high for the first 16 cycles.
// ==============================
`timescale 1ns/1ns

module tb_clock_gen
(
    output logic o_clock,
    output logic o_reset
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 16;

    initial
    begin
        o_clock = 1'b0;
        forever #HALF_PERIOD o_clock = ~o_clock;
    end

    // Released on a falling edge, like every other DUT input.
    initial
    begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge o_clock);
        o_reset = 1'b0;
    end

endmodule

/* gcm_tag_verify.sv */
// ==============================
// GCM tag verifier, one block per 129 cycles.
// E(K,J0) and H come from an external cipher in the header.
// ==============================
`timescale 1ns/1ns

module gcm_tag_verify
(
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_valid,
    input  logic                i_sop,
    input  gcm_pkg::frame_hdr_t i_hdr,
    input  gcm_pkg::block_t     i_text,
    input  logic                i_clear_fault,
    output logic                o_ready,
    output logic                o_tag_valid,
    output logic                o_fail,
    output logic                o_fault_sop_busy
);

    logic            hdr_load;
    logic            text_take;
    logic            mult_start;
    logic            mult_done;
    logic            final_pulse;
    logic            zero;
    logic [1:0]      sel;
    gcm_pkg::block_t ghash;

    // Frame control.
    tag_sequencer_fsm i_tag_sequencer_fsm
    (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_valid          (i_valid),
        .i_sop            (i_sop),
        .i_clear_fault    (i_clear_fault),
        .i_mult_done      (mult_done),
        .i_zero           (zero),
        .o_ready          (o_ready),
        .o_hdr_load       (hdr_load),
        .o_text_take      (text_take),
        .o_mult_start     (mult_start),
        .o_final          (final_pulse),
        .o_fault_sop_busy (o_fault_sop_busy),
        .o_sel            (sel)
    );

    // Text blocks left.
    block_timer i_block_timer
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_load        (hdr_load),
        .i_length_text (i_hdr.length_text),
        .i_dec         (text_take),
        .o_zero        (zero)
    );

    ghash_accumulator i_ghash_accumulator
    (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_hdr_load   (hdr_load),
        .i_hdr        (i_hdr),
        .i_text       (i_text),
        .i_text_take  (text_take),
        .i_sel        (sel),
        .i_mult_start (mult_start),
        .o_mult_done  (mult_done),
        .o_ghash      (ghash)
    );

    tag_checker i_tag_checker
    (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_hdr_load  (hdr_load),
        .i_hdr       (i_hdr),
        .i_final     (final_pulse),
        .i_ghash     (ghash),
        .o_tag_valid (o_tag_valid),
        .o_fail      (o_fail)
    );

endmodule

/* tag_checker.sv */
// ==============================
// Tag compare against mask XOR GHASH.
// o_fail holds until the next accepted header.
// ==============================
`timescale 1ns/1ns

module tag_checker
(
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_hdr_load,
    input  gcm_pkg::frame_hdr_t i_hdr,
    input  logic                i_final,
    input  gcm_pkg::block_t     i_ghash,
    output logic                o_tag_valid,
    output logic                o_fail
);

    gcm_pkg::block_t tag_q;
    gcm_pkg::block_t mask_q;
    gcm_pkg::block_t regen_tag;
    logic            mismatch;
    logic            fail_q;

    // Tag and E(K,J0) are only on the header beat.
    always_ff @(posedge i_clock)
    begin
        if (i_hdr_load)
        begin
            tag_q  <= i_hdr.tag;
            mask_q <= i_hdr.tag_mask;
        end
    end

    // Regenerated tag.
    assign regen_tag = mask_q ^ i_ghash;
    assign mismatch  = (regen_tag != tag_q);

    // Verdict kept after the pulse.
    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_hdr_load)
        begin
            fail_q <= 1'b0;
        end
        else if (i_final)
        begin
            fail_q <= mismatch;
        end
    end

    // i_final is a one-cycle pulse from the sequencer state.
    assign o_tag_valid = i_final;
    assign o_fail      = i_final ? mismatch : fail_q;

endmodule

/* ghash_accumulator.sv */
// ==============================
// GHASH state Y with one serial multiplier.
// Header fields are locked at the header beat.
// ==============================
`timescale 1ns/1ns

module ghash_accumulator
(
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_hdr_load,
    input  gcm_pkg::frame_hdr_t i_hdr,
    input  gcm_pkg::block_t     i_text,
    input  logic                i_text_take,
    input  logic [1:0]          i_sel,
    input  logic                i_mult_start,
    output logic                o_mult_done,
    output gcm_pkg::block_t     o_ghash
);

    gcm_pkg::block_t hash_key_q;
    gcm_pkg::block_t aad_q;
    gcm_pkg::block_t length_q;
    gcm_pkg::block_t text_q;
    gcm_pkg::block_t y_acc;
    gcm_pkg::block_t block_in;
    gcm_pkg::block_t mult_x;
    gcm_pkg::block_t product;
    logic            mult_busy;

    // Header lock, length word is len(A) || len(C).
    // Y restarts from zero for each frame.
    always_ff @(posedge i_clock)
    begin
        if (i_hdr_load)
        begin
            hash_key_q <= i_hdr.hash_key;
            aad_q      <= i_hdr.aad;
            length_q   <= {i_hdr.length_aad, i_hdr.length_text};
            y_acc      <= '0;
        end
        else if (o_mult_done)
        begin
            y_acc <= product;
        end
    end

    // Text beat held until its multiply starts.
    always_ff @(posedge i_clock)
    begin
        if (i_text_take)
        begin
            text_q <= i_text;
        end
    end

    // Block select into the hash.
    always_comb
    begin
        case (i_sel)
            gcm_pkg::SEL_TEXT:   block_in = text_q;
            gcm_pkg::SEL_LENGTH: block_in = length_q;
            default:             block_in = aad_q;
        endcase
    end

    assign mult_x = y_acc ^ block_in;

    gf128_multiplier i_gf128_multiplier
    (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_start   (i_mult_start),
        .i_x       (mult_x),
        .i_h       (hash_key_q),
        .o_done    (o_mult_done),
        .o_busy    (mult_busy),
        .o_product (product)
    );

    assign o_ghash = y_acc;

    // A new header must not change H under a running multiply.
    a_no_hdr_busy: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_hdr_load |-> !mult_busy
    );

endmodule

/* tag_sequencer_fsm.sv */
// ==============================
// Frame FSM: AAD, text blocks, length word.
// Header beat is taken in IDLE only; a busy i_sop sets a sticky fault.
// ==============================
`timescale 1ns/1ns

module tag_sequencer_fsm
(
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_valid,
    input  logic       i_sop,
    input  logic       i_clear_fault,
    input  logic       i_mult_done,
    input  logic       i_zero,
    output logic       o_ready,
    output logic       o_hdr_load,
    output logic       o_text_take,
    output logic       o_mult_start,
    output logic       o_final,
    output logic       o_fault_sop_busy,
    output logic [1:0] o_sel
);

    gcm_pkg::seq_state_e state;
    gcm_pkg::seq_state_e state_next;
    logic                running;
    logic                text_pend;

    // ==============================
    // Next state and strobes.
    // ==============================
    always_comb
    begin
        state_next   = state;
        o_hdr_load   = 1'b0;
        o_text_take  = 1'b0;
        o_mult_start = 1'b0;
        o_final      = 1'b0;
        o_ready      = 1'b0;
        o_sel        = gcm_pkg::SEL_AAD;
        case (state)
            gcm_pkg::IDLE:
            begin
                if (i_valid && i_sop)
                begin
                    o_hdr_load = 1'b1;
                    state_next = gcm_pkg::AAD;
                end
            end
            gcm_pkg::AAD:
            begin
                o_mult_start = !running;
                // No text at all goes straight to the length word.
                if (i_mult_done)
                begin
                    state_next = i_zero ? gcm_pkg::LENGTH : gcm_pkg::TEXT;
                end
            end
            gcm_pkg::TEXT:
            begin
                o_sel = gcm_pkg::SEL_TEXT;
                // Ready also in the done cycle, Y is written before the start.
                o_ready      = !i_zero && !text_pend && (!running || i_mult_done);
                o_text_take  = o_ready && i_valid && !i_sop;
                o_mult_start = text_pend;
                if (i_mult_done && i_zero)
                begin
                    state_next = gcm_pkg::LENGTH;
                end
            end
            gcm_pkg::LENGTH:
            begin
                o_sel        = gcm_pkg::SEL_LENGTH;
                o_mult_start = !running;
                if (i_mult_done)
                begin
                    state_next = gcm_pkg::DONE;
                end
            end
            default:
            begin
                // Final GHASH is in Y here.
                o_final    = 1'b1;
                state_next = gcm_pkg::IDLE;
            end
        endcase
    end

    // ==============================
    // State registers.
    // ==============================
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state     <= gcm_pkg::IDLE;
            running   <= 1'b0;
            text_pend <= 1'b0;
        end
        else
        begin
            state <= state_next;
            // Multiplier in flight, from start to done.
            running <= o_mult_start || (running && !i_mult_done);
            // Text block latched, start goes out next cycle.
            text_pend <= o_text_take;
        end
    end

    // Sticky fault, clear has priority over a new event.
    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_clear_fault)
        begin
            o_fault_sop_busy <= 1'b0;
        end
        else if (i_valid && i_sop && (state != gcm_pkg::IDLE))
        begin
            o_fault_sop_busy <= 1'b1;
        end
    end

    // A done pulse only ends a multiply this FSM started.
    a_done_in_flight: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_mult_done |-> running
    );

endmodule

/* block_timer.sv */
// ==============================
// Count of text blocks left in the frame.
// Text length is taken in whole blocks, up to 1023.
// ==============================
`timescale 1ns/1ns
`include "ghash_settings.svh"

module block_timer
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_load,
    input  logic [`GCM_NB_BLOCK/2-1:0]  i_length_text,
    input  logic                        i_dec,
    output logic                        o_zero
);

    logic [`GCM_NB_TIMER-1:0] blocks_left;

    // Load at the header beat, one down per accepted text beat.
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            blocks_left <= '0;
        end
        else if (i_load)
        begin
            // Bit length to block count.
            blocks_left <= i_length_text[`GCM_LOG2_BLOCK_BITS +: `GCM_NB_TIMER];
        end
        else if (i_dec)
        begin
            blocks_left <= blocks_left - 1'b1;
        end
    end

    assign o_zero = (blocks_left == '0);

    // The sequencer drops o_ready once the last block is in.
    a_no_dec_at_zero: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_dec |-> !o_zero
    );

endmodule

/* gf128_multiplier.sv */
// ==============================
// Bit-serial multiply in GF(2^128), GCM bit order.
// o_done pulses 128 cycles after i_start; no start while busy.
// ==============================
`timescale 1ns/1ns
`include "ghash_settings.svh"

module gf128_multiplier
(
    input  logic            i_clock,
    input  logic            i_reset,
    input  logic            i_start,
    input  gcm_pkg::block_t i_x,
    input  gcm_pkg::block_t i_h,
    output logic            o_done,
    output logic            o_busy,
    output gcm_pkg::block_t o_product
);

    localparam int                  NB_COUNT = $clog2(`GCM_NB_BLOCK);
    localparam logic [NB_COUNT-1:0] LAST_BIT = NB_COUNT'(`GCM_NB_BLOCK - 1);

    gcm_pkg::block_t     z_acc;
    gcm_pkg::block_t     v_reg;
    gcm_pkg::block_t     x_reg;
    logic [NB_COUNT-1:0] bit_cnt;
    logic                busy;

    // V times x, one right shift with reduction when bit 127 falls out.
    function automatic gcm_pkg::block_t shift_v(input gcm_pkg::block_t v);
        gcm_pkg::block_t shifted;
        shifted = v >> 1;
        if (v[0])
        begin
            shifted = shifted ^ `GCM_R_POLY;
        end
        return shifted;
    endfunction

    // ==============================
    // Control.
    // ==============================

    // The start cycle handles X bit 0, so 127 busy cycles remain.
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            o_done  <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_start)
            begin
                busy    <= 1'b1;
                bit_cnt <= NB_COUNT'(1);
            end
            else if (busy)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                // Last bit handled here, product is whole next cycle.
                if (bit_cnt == LAST_BIT)
                begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // ==============================
    // Datapath.
    // ==============================

    // X is walked from its MSB, Z collects V where the bit is set.
    always_ff @(posedge i_clock)
    begin
        if (i_start)
        begin
            z_acc <= i_x[`GCM_NB_BLOCK-1] ? i_h : '0;
            v_reg <= shift_v(i_h);
            x_reg <= i_x << 1;
        end
        else if (busy)
        begin
            if (x_reg[`GCM_NB_BLOCK-1])
            begin
                z_acc <= z_acc ^ v_reg;
            end
            v_reg <= shift_v(v_reg);
            x_reg <= x_reg << 1;
        end
    end

    assign o_product = z_acc;
    assign o_busy    = busy;

    // The sequencer must wait for the product before the next block.
    a_no_start_busy: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_start |-> !busy
    );

endmodule

/* gcm_pkg.sv */
// ==============================
// Shared types of the tag verifier.
// The header carries the hash key and the tag mask from outside.
// ==============================
`include "ghash_settings.svh"

package gcm_pkg;

    // One 128-bit block, bit 127 is GCM bit 0.
    typedef logic [`GCM_NB_BLOCK-1:0] block_t;

    // Header beat of a frame.
    // Lengths are in bits, as in the GCM length word.
    typedef struct packed {
        block_t                      hash_key;
        block_t                      aad;
        logic [`GCM_NB_BLOCK/2-1:0]  length_aad;
        logic [`GCM_NB_BLOCK/2-1:0]  length_text;
        block_t                      tag;
        block_t                      tag_mask;
    } frame_hdr_t;

    // Frame sequencer states.
    typedef enum logic [2:0] {
        IDLE,
        AAD,
        TEXT,
        LENGTH,
        DONE
    } seq_state_e;

    // Block select codes from the sequencer to the accumulator.
    localparam logic [1:0] SEL_AAD    = 2'd0;
    localparam logic [1:0] SEL_TEXT   = 2'd1;
    localparam logic [1:0] SEL_LENGTH = 2'd2;

endpackage

/* ghash_settings.svh */
// ==============================
// Widths and constants of the GHASH tag path.
// GCM_NB_TIMER must hold the largest text block count of a frame.
// ==============================
`ifndef GHASH_SETTINGS_SVH
`define GHASH_SETTINGS_SVH

// Width of one GCM block in bits.
`define GCM_NB_BLOCK 128

// Width of the text block counter, 0 to 1023 blocks.
`define GCM_NB_TIMER 10

// Shift from a bit length to a whole block count.
`define GCM_LOG2_BLOCK_BITS 7

// Reduction constant R, 0xE1 followed by 120 zero bits.
`define GCM_R_POLY {8'he1, 120'd0}

`endif
